/* src/lsu_params.svh */
// Only an LSU_XLEN of 32 is supported by the byte lanes of the stage and the RAM
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width in bits
`define LSU_XLEN 32

// word-address bits of the shared data RAM
// 8 bits give 256 words, so 1 KiB from address zero
`define LSU_RAM_AW 8

`endif

/* src/lsu_pkg.sv */
// Enum encodings here are shared with the execute stage and the testbench and must not be reordered
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

	// data or address word
	typedef logic [`LSU_XLEN-1:0] word_t;

	// destination register number
	typedef logic [4:0] reg_idx_t;

	// one strobe bit per byte lane
	typedef logic [`LSU_XLEN/8-1:0] strb_t;

	// anything but ld_none marks a load
	typedef enum logic [2:0] {
		ld_none = 3'd0,
		ld_lb   = 3'd1,
		ld_lh   = 3'd2,
		ld_lw   = 3'd3,
		ld_lbu  = 3'd4,
		ld_lhu  = 3'd5
	} load_type_e;

	typedef enum logic [1:0] {
		st_none = 2'd0,
		st_sb   = 2'd1,
		st_sh   = 2'd2,
		st_sw   = 2'd3
	} store_type_e;

	// bytes per access, AXI style encoding
	typedef enum logic [2:0] {
		size_1 = 3'd0,
		size_2 = 3'd1,
		size_4 = 3'd2
	} bus_size_e;

	// execute result handed to the load/store stage
	typedef struct packed {
		logic        wd;
		reg_idx_t    wreg;
		word_t       alu_result;
		word_t       store_data;
		load_type_e  load_type;
		store_type_e store_type;
	} ex_to_ls_t;

	typedef struct packed {
		logic     wd;
		reg_idx_t wreg;
		word_t    wdata;
	} ls_to_wb_t;

	// forward record back to decode
	typedef struct packed {
		logic     need_stall;
		logic     fwd_en;
		reg_idx_t wreg;
		word_t    wdata;
	} ls_fwd_t;

	typedef struct packed {
		word_t     addr;
		logic      write;
		bus_size_e size;
		word_t     wdata;
		strb_t     wstrb;
	} mem_req_t;

endpackage

`default_nettype wire

/* src/lsu_stage.sv */
// Accesses that cross a word boundary are undefined and not detected, and one memory access is in flight at most
`default_nettype none

module lsu_stage (
	input  wire                        clock,
	input  wire                        rstn,
	input  wire lsu_pkg::ex_to_ls_t    ex_req_i,
	input  wire                        ex_valid_i,
	output logic                       lsu_allowin_o,
	output lsu_pkg::ls_to_wb_t         wb_o,
	output logic                       lsu_to_wbu_valid_o,
	input  wire                        wbu_allowin_i,
	output lsu_pkg::ls_fwd_t           fwd_o,
	output lsu_pkg::mem_req_t          mem_req_o,
	output logic                       mem_sel_o,
	input  wire lsu_pkg::word_t        mem_rdata_i,
	input  wire                        mem_pvalid_i
);

	// stage register and its control
	lsu_pkg::ex_to_ls_t ls_q;
	logic               ls_valid;
	logic               mem_done;
	lsu_pkg::word_t     rdata_hold;

	logic               is_load;
	logic               is_store;
	logic               is_mem;
	logic               ready_go;
	logic [1:0]         byte_off;
	lsu_pkg::strb_t     base_strb;
	lsu_pkg::bus_size_e acc_size;
	lsu_pkg::word_t     load_shifted;
	lsu_pkg::word_t     load_value;
	lsu_pkg::word_t     result;

	assign is_load  = ls_q.load_type != lsu_pkg::ld_none;
	assign is_store = ls_q.store_type != lsu_pkg::st_none;
	assign is_mem   = is_load | is_store;
	assign byte_off = ls_q.alu_result[1:0];

	// non-memory entries finish at once, memory ones after the response
	assign ready_go           = ~is_mem | mem_done;
	assign lsu_allowin_o      = ~ls_valid | (ready_go & wbu_allowin_i);
	assign lsu_to_wbu_valid_o = ls_valid & ready_go;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			ls_valid <= 1'b0;
		end else if (lsu_allowin_o) begin
			ls_valid <= ex_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (ex_valid_i && lsu_allowin_o) begin
			ls_q <= ex_req_i;
		end
	end

	// done flag clears whenever the stage takes or drops an entry
	always_ff @(posedge clock) begin
		if (!rstn) begin
			mem_done <= 1'b0;
		end else if (lsu_allowin_o) begin
			mem_done <= 1'b0;
		end else if (mem_sel_o && mem_pvalid_i) begin
			mem_done <= 1'b1;
		end
	end

	// response hold, keeps wb_o steady under back-pressure
	always_ff @(posedge clock) begin
		if (mem_sel_o && mem_pvalid_i) begin
			rdata_hold <= mem_rdata_i;
		end
	end

	// strobes and size from the access type
	always_comb begin
		base_strb = 4'b1111;
		acc_size  = lsu_pkg::size_4;
		if (is_load) begin
			case (ls_q.load_type)
				lsu_pkg::ld_lb, lsu_pkg::ld_lbu: acc_size = lsu_pkg::size_1;
				lsu_pkg::ld_lh, lsu_pkg::ld_lhu: acc_size = lsu_pkg::size_2;
				default:                         acc_size = lsu_pkg::size_4;
			endcase
		end else begin
			case (ls_q.store_type)
				lsu_pkg::st_sb: begin
					base_strb = 4'b0001;
					acc_size  = lsu_pkg::size_1;
				end
				lsu_pkg::st_sh: begin
					base_strb = 4'b0011;
					acc_size  = lsu_pkg::size_2;
				end
				default: begin
					base_strb = 4'b1111;
					acc_size  = lsu_pkg::size_4;
				end
			endcase
		end
	end

	// sel stays up until the one response cycle
	assign mem_sel_o = ls_valid & is_mem & ~mem_done;

	always_comb begin
		mem_req_o.addr  = ls_q.alu_result;
		mem_req_o.write = is_store;
		mem_req_o.size  = acc_size;
		// move data and strobes into the addressed lanes
		mem_req_o.wdata = ls_q.store_data << {byte_off, 3'b000};
		mem_req_o.wstrb = is_store ? (base_strb << byte_off) : 4'b0000;
	end

	// loaded byte or half down to lane 0
	assign load_shifted = rdata_hold >> {byte_off, 3'b000};

	always_comb begin
		case (ls_q.load_type)
			lsu_pkg::ld_lb:  load_value = lsu_pkg::word_t'(signed'(load_shifted[7:0]));
			lsu_pkg::ld_lh:  load_value = lsu_pkg::word_t'(signed'(load_shifted[15:0]));
			lsu_pkg::ld_lbu: load_value = lsu_pkg::word_t'(load_shifted[7:0]);
			lsu_pkg::ld_lhu: load_value = lsu_pkg::word_t'(load_shifted[15:0]);
			default:         load_value = load_shifted;
		endcase
	end

	assign result = is_load ? load_value : ls_q.alu_result;

	always_comb begin
		wb_o.wd    = ls_q.wd;
		wb_o.wreg  = ls_q.wreg;
		wb_o.wdata = result;
	end

	// decode must wait on a load still waiting for its data
	always_comb begin
		fwd_o.need_stall = ls_valid & is_load & ~mem_done;
		fwd_o.fwd_en     = ls_valid & ls_q.wd & (ls_q.wreg != '0);
		fwd_o.wreg       = ls_q.wreg;
		fwd_o.wdata      = result;
	end

	// request held steady across arbitration and RAM latency
	a_req_stable: assert property (@(posedge clock) disable iff (!rstn)
		mem_sel_o && !mem_pvalid_i |=> mem_sel_o && $stable(mem_req_o));

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
// Two masters only, each master must hold sel and its request until its single response
`default_nettype none

module bus_arbiter (
	input  wire                      clock,
	input  wire                      rstn,
	input  wire lsu_pkg::mem_req_t   m0_req_i,
	input  wire                      m0_sel_i,
	output lsu_pkg::word_t           m0_rdata_o,
	output logic                     m0_pvalid_o,
	input  wire lsu_pkg::mem_req_t   m1_req_i,
	input  wire                      m1_sel_i,
	output lsu_pkg::word_t           m1_rdata_o,
	output logic                     m1_pvalid_o,
	output lsu_pkg::mem_req_t        bus_req_o,
	output logic                     bus_sel_o,
	input  wire lsu_pkg::word_t      bus_rdata_i,
	input  wire                      bus_pvalid_i
);

	// grant register
	// last_win is the current owner while held and the previous winner otherwise
	logic held;
	logic last_win;
	logic pick;

	// on a tie the master that lost last time wins
	assign pick = (m0_sel_i && m1_sel_i) ? ~last_win : m1_sel_i;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			held     <= 1'b0;
			last_win <= 1'b1;
		end else if (!held) begin
			if (m0_sel_i || m1_sel_i) begin
				held     <= 1'b1;
				last_win <= pick;
			end
		end else if (bus_pvalid_i) begin
			// release after the response cycle
			held <= 1'b0;
		end
	end

	// granted request straight through to the RAM
	assign bus_req_o = last_win ? m1_req_i : m0_req_i;
	assign bus_sel_o = held & (last_win ? m1_sel_i : m0_sel_i);

	// response only to the owner
	assign m0_pvalid_o = held & ~last_win & bus_pvalid_i;
	assign m1_pvalid_o = held & last_win & bus_pvalid_i;
	assign m0_rdata_o  = (held && !last_win) ? bus_rdata_i : '0;
	assign m1_rdata_o  = (held && last_win) ? bus_rdata_i : '0;

	// the one owner still holds its request when the response comes
	a_one_owner: assert property (@(posedge clock) disable iff (!rstn)
		bus_pvalid_i |-> (last_win ? m1_sel_i : m0_sel_i));

	// the RAM never answers a request that was not granted
	a_resp_granted: assert property (@(posedge clock) disable iff (!rstn)
		bus_pvalid_i |-> held);

endmodule

`default_nettype wire

/* src/data_ram.sv */
// Only the low 2^(LSU_RAM_AW+2) bytes are backed, higher address bits are not decoded
`default_nettype none

`include "lsu_params.svh"

module data_ram (
	input  wire                      clock,
	input  wire                      rstn,
	input  wire lsu_pkg::mem_req_t   req_i,
	input  wire                      sel_i,
	output lsu_pkg::word_t           rdata_o,
	output logic                     pvalid_o
);

	localparam int unsigned ram_words = 1 << `LSU_RAM_AW;

	lsu_pkg::word_t          mem [ram_words];
	logic [`LSU_RAM_AW-1:0]  word_idx;
	logic                    busy;
	logic                    accept;

	// word address, byte offset dropped
	assign word_idx = req_i.addr[`LSU_RAM_AW+1:2];

	// a request counts once, busy stays set while sel is held
	assign accept = sel_i & ~busy;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			busy     <= 1'b0;
			pvalid_o <= 1'b0;
		end else begin
			busy     <= sel_i;
			pvalid_o <= accept;
		end
	end

	// byte-enabled write, or registered read
	always_ff @(posedge clock) begin
		if (accept) begin
			if (req_i.write) begin
				for (int b = 0; b < $bits(lsu_pkg::strb_t); b++) begin
					if (req_i.wstrb[b]) begin
						mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
					end
				end
			end else begin
				rdata_o <= mem[word_idx];
			end
		end
	end

	a_addr_range: assert property (@(posedge clock) disable iff (!rstn)
		sel_i |-> (req_i.addr >> (`LSU_RAM_AW + 2)) == '0);

endmodule

`default_nettype wire

/* src/fetch_port.sv */
// Fetch addresses are expected word aligned, and one fetch is in flight at a time
`default_nettype none

module fetch_port (
	input  wire                      clock,
	input  wire                      rstn,
	input  wire lsu_pkg::word_t      fetch_addr_i,
	input  wire                      fetch_valid_i,
	output logic                     fetch_ready_o,
	output lsu_pkg::word_t           fetch_inst_o,
	output logic                     fetch_inst_valid_o,
	input  wire                      fetch_inst_ready_i,
	output lsu_pkg::mem_req_t        mem_req_o,
	output logic                     mem_sel_o,
	input  wire lsu_pkg::word_t      mem_rdata_i,
	input  wire                      mem_pvalid_i
);

	typedef enum logic [1:0] {
		s_idle,
		s_request,
		s_hold
	} fetch_state_e;

	fetch_state_e   state;
	lsu_pkg::word_t addr_q;
	lsu_pkg::word_t inst_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle: if (fetch_valid_i) state <= s_request;
				s_request: if (mem_pvalid_i) state <= s_hold;
				// accept again only once the word is taken
				s_hold: if (fetch_inst_ready_i) state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	// address and fetched word
	always_ff @(posedge clock) begin
		if (state == s_idle && fetch_valid_i) begin
			addr_q <= fetch_addr_i;
		end
		if (state == s_request && mem_pvalid_i) begin
			inst_q <= mem_rdata_i;
		end
	end

	assign fetch_ready_o      = state == s_idle;
	assign fetch_inst_valid_o = state == s_hold;
	assign fetch_inst_o       = inst_q;
	assign mem_sel_o          = state == s_request;

	// always a full word read
	always_comb begin
		mem_req_o.addr  = addr_q;
		mem_req_o.write = 1'b0;
		mem_req_o.size  = lsu_pkg::size_4;
		mem_req_o.wdata = '0;
		mem_req_o.wstrb = '0;
	end

endmodule

`default_nettype wire

/* src/lsu_mem_top.sv */
// Stage is master 0 and fetch is master 1 of one shared single-port RAM
`default_nettype none

module lsu_mem_top (
	input  wire                      clock,
	input  wire                      rstn,
	input  wire lsu_pkg::ex_to_ls_t  ex_req_i,
	input  wire                      ex_valid_i,
	output logic                     lsu_allowin_o,
	output lsu_pkg::ls_to_wb_t       wb_o,
	output logic                     lsu_to_wbu_valid_o,
	input  wire                      wbu_allowin_i,
	output lsu_pkg::ls_fwd_t         fwd_o,
	input  wire lsu_pkg::word_t      fetch_addr_i,
	input  wire                      fetch_valid_i,
	output logic                     fetch_ready_o,
	output lsu_pkg::word_t           fetch_inst_o,
	output logic                     fetch_inst_valid_o,
	input  wire                      fetch_inst_ready_i
);

	// stage side of the arbiter
	lsu_pkg::mem_req_t ls_req;
	logic              ls_sel;
	lsu_pkg::word_t    ls_rdata;
	logic              ls_pvalid;

	// fetch side of the arbiter
	lsu_pkg::mem_req_t fe_req;
	logic              fe_sel;
	lsu_pkg::word_t    fe_rdata;
	logic              fe_pvalid;

	// arbiter to RAM
	lsu_pkg::mem_req_t bus_req;
	logic              bus_sel;
	lsu_pkg::word_t    bus_rdata;
	logic              bus_pvalid;

	lsu_stage i_lsu_stage (
		.clock              (clock),
		.rstn               (rstn),
		.ex_req_i           (ex_req_i),
		.ex_valid_i         (ex_valid_i),
		.lsu_allowin_o      (lsu_allowin_o),
		.wb_o               (wb_o),
		.lsu_to_wbu_valid_o (lsu_to_wbu_valid_o),
		.wbu_allowin_i      (wbu_allowin_i),
		.fwd_o              (fwd_o),
		.mem_req_o          (ls_req),
		.mem_sel_o          (ls_sel),
		.mem_rdata_i        (ls_rdata),
		.mem_pvalid_i       (ls_pvalid)
	);

	fetch_port i_fetch_port (
		.clock              (clock),
		.rstn               (rstn),
		.fetch_addr_i       (fetch_addr_i),
		.fetch_valid_i      (fetch_valid_i),
		.fetch_ready_o      (fetch_ready_o),
		.fetch_inst_o       (fetch_inst_o),
		.fetch_inst_valid_o (fetch_inst_valid_o),
		.fetch_inst_ready_i (fetch_inst_ready_i),
		.mem_req_o          (fe_req),
		.mem_sel_o          (fe_sel),
		.mem_rdata_i        (fe_rdata),
		.mem_pvalid_i       (fe_pvalid)
	);

	bus_arbiter i_bus_arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.m0_req_i     (ls_req),
		.m0_sel_i     (ls_sel),
		.m0_rdata_o   (ls_rdata),
		.m0_pvalid_o  (ls_pvalid),
		.m1_req_i     (fe_req),
		.m1_sel_i     (fe_sel),
		.m1_rdata_o   (fe_rdata),
		.m1_pvalid_o  (fe_pvalid),
		.bus_req_o    (bus_req),
		.bus_sel_o    (bus_sel),
		.bus_rdata_i  (bus_rdata),
		.bus_pvalid_i (bus_pvalid)
	);

	data_ram i_data_ram (
		.clock    (clock),
		.rstn     (rstn),
		.req_i    (bus_req),
		.sel_i    (bus_sel),
		.rdata_o  (bus_rdata),
		.pvalid_o (bus_pvalid)
	);

endmodule

`default_nettype wire

/* sim/lsu_mem_tb.sv */
// Loads only read bytes stored earlier in the run, since the RAM and the reference model start unset
`default_nettype none

`include "lsu_params.svh"

module lsu_mem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [`LSU_RAM_AW+1:0] byte_idx_t;

	// about 85 operations of at most 10 cycles each with margin on top
	localparam int unsigned max_cycles = 3000;

	logic                clock;
	logic                rstn;
	lsu_pkg::ex_to_ls_t  ex_req;
	logic                ex_valid;
	logic                lsu_allowin;
	lsu_pkg::ls_to_wb_t  wb;
	logic                lsu_to_wbu_valid;
	logic                wbu_allowin;
	lsu_pkg::ls_fwd_t    fwd;
	lsu_pkg::word_t      fetch_addr;
	logic                fetch_valid;
	logic                fetch_ready;
	lsu_pkg::word_t      fetch_inst;
	logic                fetch_inst_valid;
	logic                fetch_inst_ready;

	// reference memory with one entry per byte
	logic [7:0]     ref_mem [1 << (`LSU_RAM_AW + 2)];
	lsu_pkg::word_t word_addrs [8];
	int             seed = 19;
	int unsigned    cycle_count = 0;

	lsu_mem_top i_lsu_mem_top (
		.clock              (clock),
		.rstn               (rstn),
		.ex_req_i           (ex_req),
		.ex_valid_i         (ex_valid),
		.lsu_allowin_o      (lsu_allowin),
		.wb_o               (wb),
		.lsu_to_wbu_valid_o (lsu_to_wbu_valid),
		.wbu_allowin_i      (wbu_allowin),
		.fwd_o              (fwd),
		.fetch_addr_i       (fetch_addr),
		.fetch_valid_i      (fetch_valid),
		.fetch_ready_o      (fetch_ready),
		.fetch_inst_o       (fetch_inst),
		.fetch_inst_valid_o (fetch_inst_valid),
		.fetch_inst_ready_i (fetch_inst_ready)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic stop_on_error();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout after %0d cycles, a handshake never completed", cycle_count);
			stop_on_error();
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_error();
		end
	endtask

	// all stimulus changes 1 ns after the rising edge
	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	function automatic lsu_pkg::ex_to_ls_t make_req(input logic wd, input lsu_pkg::reg_idx_t wreg,
			input lsu_pkg::word_t alu, input lsu_pkg::word_t sdata,
			input lsu_pkg::load_type_e lt, input lsu_pkg::store_type_e st);
		lsu_pkg::ex_to_ls_t r;
		r.wd         = wd;
		r.wreg       = wreg;
		r.alu_result = alu;
		r.store_data = sdata;
		r.load_type  = lt;
		r.store_type = st;
		return r;
	endfunction

	function automatic lsu_pkg::word_t rand_word_addr();
		return 32'(($random(seed) & ((1 << `LSU_RAM_AW) - 1)) << 2);
	endfunction

	// expected load result straight from the byte model
	function automatic lsu_pkg::word_t ref_load(input lsu_pkg::word_t addr,
			input lsu_pkg::load_type_e lt);
		logic [7:0] b [4];
		for (int k = 0; k < 4; k++) begin
			b[k] = ref_mem[byte_idx_t'(addr + 32'(k))];
		end
		case (lt)
			lsu_pkg::ld_lb:  return {{24{b[0][7]}}, b[0]};
			lsu_pkg::ld_lbu: return {24'h0, b[0]};
			lsu_pkg::ld_lh:  return {{16{b[1][7]}}, b[1], b[0]};
			lsu_pkg::ld_lhu: return {16'h0, b[1], b[0]};
			default:         return {b[3], b[2], b[1], b[0]};
		endcase
	endfunction

	function automatic void ref_store(input lsu_pkg::word_t addr, input lsu_pkg::store_type_e st,
			input lsu_pkg::word_t data);
		int n;
		case (st)
			lsu_pkg::st_sb: n = 1;
			lsu_pkg::st_sh: n = 2;
			default:        n = 4;
		endcase
		for (int k = 0; k < n; k++) begin
			ref_mem[byte_idx_t'(addr + 32'(k))] = data[8*k +: 8];
		end
	endfunction

	// hold the entry until the stage takes it and return 1 ns after the accepting edge
	task automatic send(input lsu_pkg::ex_to_ls_t req);
		ex_req   = req;
		ex_valid = 1'b1;
		#1;
		while (!lsu_allowin) begin
			tick();
			#1;
		end
		tick();
		ex_valid = 1'b0;
	endtask

	task automatic wait_result(output lsu_pkg::ls_to_wb_t res);
		#1;
		while (!lsu_to_wbu_valid) begin
			tick();
			#1;
		end
		res = wb;
	endtask

	task automatic do_op(input lsu_pkg::ex_to_ls_t req, output lsu_pkg::ls_to_wb_t res);
		send(req);
		wait_result(res);
		tick();
	endtask

	task automatic store(input lsu_pkg::word_t addr, input lsu_pkg::store_type_e st,
			input lsu_pkg::word_t data);
		lsu_pkg::ls_to_wb_t res;
		do_op(make_req(1'b0, 5'd0, addr, data, lsu_pkg::ld_none, st), res);
		ref_store(addr, st, data);
	endtask

	task automatic load_check(input lsu_pkg::word_t addr, input lsu_pkg::load_type_e lt);
		lsu_pkg::ls_to_wb_t res;
		do_op(make_req(1'b1, 5'd9, addr, '0, lt, lsu_pkg::st_none), res);
		check("wb_o.wdata", res.wdata, ref_load(addr, lt));
		check("wb_o.wreg", 32'(res.wreg), 32'd9);
	endtask

	task automatic fetch_check(input lsu_pkg::word_t addr);
		fetch_addr       = addr;
		fetch_valid      = 1'b1;
		fetch_inst_ready = 1'b1;
		#1;
		while (!fetch_ready) begin
			tick();
			#1;
		end
		tick();
		fetch_valid = 1'b0;
		#1;
		while (!fetch_inst_valid) begin
			tick();
			#1;
		end
		check("fetch_inst_o", fetch_inst, ref_load(addr, lsu_pkg::ld_lw));
		tick();
		fetch_inst_ready = 1'b0;
	endtask

	task automatic test_reset_state();
		#1;
		check("lsu_to_wbu_valid_o", 32'(lsu_to_wbu_valid), 32'd0);
		check("fetch_inst_valid_o", 32'(fetch_inst_valid), 32'd0);
		check("fwd_o.fwd_en", 32'(fwd.fwd_en), 32'd0);
		check("lsu_allowin_o", 32'(lsu_allowin), 32'd1);
		check("fetch_ready_o", 32'(fetch_ready), 32'd1);
		tick();
	endtask

	task automatic test_word_store_load();
		for (int i = 0; i < 8; i++) begin
			word_addrs[i] = rand_word_addr();
			store(word_addrs[i], lsu_pkg::st_sw, $random(seed));
		end
		for (int i = 0; i < 8; i++) begin
			load_check(word_addrs[i], lsu_pkg::ld_lw);
		end
	endtask

	task automatic test_sub_word();
		lsu_pkg::word_t base;
		for (int r = 0; r < 2; r++) begin
			base = rand_word_addr();
			store(base, lsu_pkg::st_sw, $random(seed));
			for (int off = 0; off < 4; off++) begin
				store(base + 32'(off), lsu_pkg::st_sb, $random(seed));
				load_check(base + 32'(off), lsu_pkg::ld_lb);
				load_check(base + 32'(off), lsu_pkg::ld_lbu);
			end
			// halfwords that stay inside the word
			for (int off = 0; off < 3; off++) begin
				store(base + 32'(off), lsu_pkg::st_sh, $random(seed));
				load_check(base + 32'(off), lsu_pkg::ld_lh);
				load_check(base + 32'(off), lsu_pkg::ld_lhu);
			end
		end
	endtask

	// one ALU entry per cycle with each result seen the cycle after its accept
	task automatic test_alu_stream();
		lsu_pkg::ex_to_ls_t reqs [6];
		for (int i = 0; i < 6; i++) begin
			reqs[i] = make_req((i != 2) && (i != 4), 5'(i * 5), $random(seed), $random(seed),
				lsu_pkg::ld_none, lsu_pkg::st_none);
		end
		for (int i = 0; i <= 6; i++) begin
			ex_valid = i < 6;
			if (i < 6) begin
				ex_req = reqs[i];
			end
			#1;
			if (i < 6) begin
				check("lsu_allowin_o", 32'(lsu_allowin), 32'd1);
			end
			if (i > 0) begin
				check("lsu_to_wbu_valid_o", 32'(lsu_to_wbu_valid), 32'd1);
				check("wb_o.wd", 32'(wb.wd), 32'(reqs[i-1].wd));
				check("wb_o.wreg", 32'(wb.wreg), 32'(reqs[i-1].wreg));
				check("wb_o.wdata", wb.wdata, reqs[i-1].alu_result);
				check("fwd_o.fwd_en", 32'(fwd.fwd_en),
					32'(reqs[i-1].wd && (reqs[i-1].wreg != 5'd0)));
				check("fwd_o.wreg", 32'(fwd.wreg), 32'(reqs[i-1].wreg));
				check("fwd_o.wdata", fwd.wdata, reqs[i-1].alu_result);
				check("fwd_o.need_stall", 32'(fwd.need_stall), 32'd0);
			end
			tick();
		end
		#1;
		check("lsu_to_wbu_valid_o", 32'(lsu_to_wbu_valid), 32'd0);
		tick();
	endtask

	task automatic test_backpressure();
		lsu_pkg::ls_to_wb_t held;
		lsu_pkg::word_t     exp_data;
		wbu_allowin = 1'b0;
		exp_data    = ref_load(word_addrs[0], lsu_pkg::ld_lw);
		send(make_req(1'b1, 5'd12, word_addrs[0], '0, lsu_pkg::ld_lw, lsu_pkg::st_none));
		#1;
		check("fwd_o.need_stall", 32'(fwd.need_stall), 32'd1);
		tick();
		wait_result(held);
		check("wb_o.wdata", held.wdata, exp_data);
		repeat (5) begin
			tick();
			#1;
			check("lsu_to_wbu_valid_o", 32'(lsu_to_wbu_valid), 32'd1);
			check("lsu_allowin_o", 32'(lsu_allowin), 32'd0);
			check("wb_o.wd", 32'(wb.wd), 32'd1);
			check("wb_o.wreg", 32'(wb.wreg), 32'd12);
			check("wb_o.wdata", wb.wdata, exp_data);
			check("fwd_o.fwd_en", 32'(fwd.fwd_en), 32'd1);
			check("fwd_o.wreg", 32'(fwd.wreg), 32'd12);
			check("fwd_o.wdata", fwd.wdata, exp_data);
			check("fwd_o.need_stall", 32'(fwd.need_stall), 32'd0);
		end
		tick();
		wbu_allowin = 1'b1;
		#1;
		check("lsu_allowin_o", 32'(lsu_allowin), 32'd1);
		tick();
		#1;
		check("lsu_to_wbu_valid_o", 32'(lsu_to_wbu_valid), 32'd0);
		tick();
	endtask

	// stage and fetch port compete for the RAM
	task automatic test_shared_bus();
		fork
			begin
				for (int i = 0; i < 4; i++) begin
					load_check(word_addrs[i], lsu_pkg::ld_lw);
				end
				for (int i = 4; i < 8; i++) begin
					load_check(word_addrs[i] + 32'd2, lsu_pkg::ld_lbu);
				end
			end
			begin
				for (int i = 4; i < 8; i++) begin
					fetch_check(word_addrs[i]);
				end
				for (int i = 0; i < 4; i++) begin
					fetch_check(word_addrs[i]);
				end
			end
		join
	endtask

	initial begin
		rstn             = 1'b0;
		ex_req           = '0;
		ex_valid         = 1'b0;
		wbu_allowin      = 1'b1;
		fetch_addr       = '0;
		fetch_valid      = 1'b0;
		fetch_inst_ready = 1'b0;
		repeat (4) tick();
		rstn = 1'b1;
		test_reset_state();
		test_word_store_load();
		test_sub_word();
		test_alu_stream();
		test_backpressure();
		test_shared_bus();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* lsu_mem_top.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_stage.sv
src/bus_arbiter.sv
src/data_ram.sv
src/fetch_port.sv
src/lsu_mem_top.sv
sim/lsu_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= lsu_mem_tb
FILELIST  ?= lsu_mem_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
